// ==== files.f ====
whack_pkg.sv
game_fsm.sv
game_timer.sv
key_mapper.sv
setting_regs.sv
mole_board.sv
seven_seg_mux.sv
whack_top.sv
whack_tb.sv

// ==== game_fsm.sv ====
module game_fsm import whack_pkg::*; (
  input  logic      clk,
  input  logic      out_rst,
  input  logic      start,
  input  count_t    time_left,
  input  logic      goal_hit,
  input  logic      final_done,
  output game_ctl_t ctl,
  output logic      won
);

  game_state_t state;
  game_state_t next_state;
  logic        enter_set;
  logic        enter_game;
  logic        enter_final;
  logic        game_over;

  // countdown and score are reloaded during the entry cycle
  assign game_over = !enter_game && ((time_left == '0) || goal_hit);

  always_comb begin
    next_state = state;
    case (state)
      INIT:    if (start) next_state = SET;
      SET:     if (start) next_state = GAME;
      GAME:    if (game_over) next_state = FINAL;
      FINAL:   if (final_done) next_state = INIT;
      default: next_state = INIT;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      state       <= INIT;
      enter_set   <= 1'b0;
      enter_game  <= 1'b0;
      enter_final <= 1'b0;
      won         <= 1'b0;
    end else begin
      state       <= next_state;
      enter_set   <= (state == INIT) && (next_state == SET);
      enter_game  <= (state == SET) && (next_state == GAME);
      enter_final <= (state == GAME) && (next_state == FINAL);
      if (state == GAME && game_over)
        won <= goal_hit;  // goal wins a tie with timeout
    end
  end

  assign ctl = '{state: state, enter_set: enter_set, enter_game: enter_game,
                 enter_final: enter_final};

endmodule

// ==== game_timer.sv ====
module game_timer import whack_pkg::*; (
  input  logic      clk,
  input  logic      out_rst,
  input  game_ctl_t ctl,
  input  count_t    time_limit,
  output count_t    time_left,
  output logic      sec_tick,
  output logic      final_done
);

  logic [TICK_W-1:0] div;
  count_t            fin_cnt;
  logic              entering;

  assign entering = ctl.enter_set | ctl.enter_game | ctl.enter_final;

  // divider restarts on each state entry so the first second is full
  assign sec_tick   = (div == TICK_W'(TICKS_PER_SEC - 1)) && !entering;
  assign final_done = (ctl.state == FINAL) && (fin_cnt >= FINAL_SECONDS);

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst)
      div <= '0;
    else if (entering || sec_tick)
      div <= '0;
    else
      div <= div + 1'b1;
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      time_left <= '0;
    end else if (ctl.enter_game) begin
      time_left <= time_limit;
    end else if (ctl.state == GAME && sec_tick && time_left != '0) begin
      time_left <= time_left - 1'b1;
    end
  end

  // seconds spent showing the result
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst)
      fin_cnt <= '0;
    else if (ctl.state != FINAL)
      fin_cnt <= '0;
    else if (sec_tick && !final_done)
      fin_cnt <= fin_cnt + 1'b1;
  end

endmodule

// ==== key_mapper.sv ====
module key_mapper import whack_pkg::*; (
  input  logic       clk,
  input  logic       out_rst,
  input  logic       key_valid,
  input  scan_code_t key_code,
  input  logic       key_break,
  output key_evt_t   evt
);

  scan_code_t held_code;
  logic       held_valid;
  logic       is_digit;
  logic       is_space;
  logic [3:0] code_digit;
  logic       repeat_make;
  logic       new_make;

  // both digit rows map onto 0-9
  always_comb begin
    is_digit   = 1'b0;
    code_digit = 4'd0;
    for (int i = 0; i < $size(KEY_CODES); i++) begin
      if (key_code == KEY_CODES[i]) begin
        is_digit   = 1'b1;
        code_digit = 4'(i % 10);
      end
    end
  end

  assign is_space    = (key_code == SPACE_CODE);
  assign repeat_make = held_valid && (key_code == held_code);
  assign new_make    = key_valid && !key_break && !repeat_make;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      held_code  <= '0;
      held_valid <= 1'b0;
    end else if (key_valid) begin
      if (key_break) begin
        if (repeat_make)
          held_valid <= 1'b0;  // matching release
      end else begin
        held_code  <= key_code;
        held_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      evt <= '0;
    end else begin
      evt.press       <= new_make && (is_digit || is_space);
      evt.digit_valid <= new_make && is_digit;
      if (new_make && is_digit)
        evt.digit <= code_digit;
      else
        evt.digit <= 4'hA;  // space marker
    end
  end

endmodule

// ==== mole_board.sv ====
module mole_board import whack_pkg::*; (
  input  logic      clk,
  input  logic      out_rst,
  input  game_ctl_t ctl,
  input  logic      sec_tick,
  input  key_evt_t  evt,
  input  set_mode_t mode,
  input  count_t    goal,
  output led_t      led,
  output count_t    score,
  output logic      goal_hit
);

  logic [8:0] lfsr;
  logic [8:0] lfsr_next;
  logic [3:0] hit_idx;
  logic       hit;

  // same taps as the board version
  always_comb begin
    lfsr_next[8] = lfsr[0];
    lfsr_next[7] = lfsr[8];
    lfsr_next[6] = lfsr[7] ^ lfsr[0];
    lfsr_next[5] = lfsr[6] ^ lfsr[0];
    lfsr_next[4] = lfsr[5];
    lfsr_next[3] = lfsr[4] ^ lfsr[0];
    lfsr_next[2] = lfsr[3];
    lfsr_next[1] = lfsr[2];
    lfsr_next[0] = lfsr[1];
  end

  // key k hits led bit 16-k, only keys 1..9 can reach a mole
  assign hit_idx = 4'(5'd16 - 5'(evt.digit));
  assign hit = evt.press && evt.digit_valid && (evt.digit != 4'd0) &&
               (evt.digit <= 4'd9) && led[hit_idx];

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lfsr  <= MOLE_SEED;
      led   <= '0;
      score <= '0;
    end else begin
      case (ctl.state)
        SET: begin
          led <= (mode == SET_TIME) ? 16'hFF00 : 16'h00FF;
        end
        GAME: begin
          if (ctl.enter_game) begin
            lfsr  <= MOLE_SEED;
            led   <= {MOLE_SEED, 7'b0};
            score <= '0;
          end else if (sec_tick) begin
            lfsr <= lfsr_next;
            led  <= {lfsr_next, 7'b0};  // new moles, old ones gone
          end else if (hit) begin
            led[hit_idx] <= 1'b0;
            score        <= score + 1'b1;
          end
        end
        default: led <= '0;
      endcase
    end
  end

  assign goal_hit = (ctl.state == GAME) && (score == goal);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module whack_tb -o whack_sim

./obj_dir/whack_sim | tee sim.log

grep -q "^test passed$" sim.log

// ==== setting_regs.sv ====
module setting_regs import whack_pkg::*; (
  input  logic      clk,
  input  logic      out_rst,
  input  game_ctl_t ctl,
  input  key_evt_t  evt,
  input  count_t    time_left,
  input  count_t    score,
  input  logic      won,
  output set_mode_t mode,
  output count_t    time_limit,
  output count_t    goal,
  output nums_t     nums
);

  bcd2_t time_bcd;
  bcd2_t goal_bcd;

  function automatic count_t to_bin(input bcd2_t b);
    return count_t'(b[7:4]) * 8'd10 + count_t'(b[3:0]);
  endfunction

  function automatic bcd2_t to_bcd(input count_t v);
    count_t tens;
    count_t ones;
    tens = v / 8'd10;
    ones = v % 8'd10;
    return {tens[3:0], ones[3:0]};
  endfunction

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      mode     <= SET_TIME;
      time_bcd <= DEFAULT_TIME;
      goal_bcd <= DEFAULT_GOAL;
    end else if (ctl.enter_set) begin
      mode     <= SET_TIME;
      time_bcd <= DEFAULT_TIME;
      goal_bcd <= DEFAULT_GOAL;
    end else if (ctl.state == SET && evt.press) begin
      if (!evt.digit_valid)
        mode <= (mode == SET_TIME) ? SET_GOAL : SET_TIME;
      else if (mode == SET_TIME)
        time_bcd <= {time_bcd[3:0], evt.digit};  // shift in from the right
      else
        goal_bcd <= {goal_bcd[3:0], evt.digit};
    end
  end

  assign time_limit = to_bin(time_bcd);
  assign goal       = to_bin(goal_bcd);

  always_comb begin
    case (ctl.state)
      SET:     nums = {time_bcd, goal_bcd};
      GAME:    nums = {to_bcd(time_left), to_bcd(score)};
      FINAL:   nums = won ? WIN_NUMS : LOSE_NUMS;
      default: nums = BLANK_NUMS;
    endcase
  end

endmodule

// ==== seven_seg_mux.sv ====
module seven_seg_mux import whack_pkg::*; (
  input  logic       clk,
  input  logic       out_rst,
  input  nums_t      nums,
  output logic [3:0] digit,
  output seg_t       display
);

  logic [SCAN_W-1:0] scan_cnt;
  logic [1:0]        sel;      // 0 is the rightmost digit
  logic [3:0]        nibble;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      scan_cnt <= '0;
      sel      <= 2'd0;
    end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
      scan_cnt <= '0;
      sel      <= sel + 2'd1;
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  assign nibble  = nums[4*sel +: 4];
  assign digit   = ~(4'b0001 << sel);  // active low select
  assign display = SEG_TABLE[nibble];

endmodule

// ==== whack_pkg.sv ====
package whack_pkg;

  typedef logic [8:0]  scan_code_t;   // {extended, byte}
  typedef logic [7:0]  bcd2_t;        // two bcd digits
  typedef logic [7:0]  count_t;
  typedef logic [15:0] led_t;
  typedef logic [15:0] nums_t;        // leftmost digit in [15:12]
  typedef logic [6:0]  seg_t;         // active low, {g,f,e,d,c,b,a}

  typedef enum logic [1:0] {INIT, SET, GAME, FINAL} game_state_t;
  typedef enum logic {SET_TIME, SET_GOAL} set_mode_t;

  typedef struct packed {
    logic       press;        // new make of a mapped key
    logic       digit_valid;  // low for space
    logic [3:0] digit;
  } key_evt_t;

  typedef struct packed {
    game_state_t state;
    logic        enter_set;
    logic        enter_game;
    logic        enter_final;
  } game_ctl_t;

  // main row 0-9 then keypad 0-9
  localparam scan_code_t KEY_CODES [20] = '{
    9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
    9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
    9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
    9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
  };
  localparam scan_code_t SPACE_CODE = 9'h029;

  localparam int TICKS_PER_SEC = 64;   // short for simulation
  localparam int TICK_W        = $clog2(TICKS_PER_SEC);
  localparam int SCAN_CYCLES   = 4;
  localparam int SCAN_W        = $clog2(SCAN_CYCLES);

  localparam logic [8:0] MOLE_SEED    = 9'h160;
  localparam bcd2_t      DEFAULT_TIME = 8'h30;
  localparam bcd2_t      DEFAULT_GOAL = 8'h10;
  localparam count_t     FINAL_SECONDS = 8'd3;

  localparam seg_t SEG_TABLE [16] = '{
    7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,  // 0 1 2 3
    7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,  // 4 5 6 7
    7'b000_0000, 7'b001_0000,                            // 8 9
    7'b000_1000, 7'b000_0011, 7'b100_0110, 7'b010_0001,  // A b C d
    7'b011_1111,                                         // dash
    7'b111_1111                                          // blank
  };

  localparam nums_t BLANK_NUMS = 16'hFFFF;
  localparam nums_t WIN_NUMS   = 16'hABCD;
  localparam nums_t LOSE_NUMS  = 16'hEEEE;

endpackage

// ==== whack_tb.sv ====
module whack_tb import whack_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic       clk;
  logic       out_rst;
  logic       start;
  logic       key_valid;
  scan_code_t key_code;
  logic       key_break;
  led_t       led;
  logic [3:0] digit;
  seg_t       display;

  int    errors;
  int    tests;
  int    failed_tests;
  int    err0;
  string cur;

  whack_top DUT (
    .clk(clk), .out_rst(out_rst), .start(start), .key_valid(key_valid),
    .key_code(key_code), .key_break(key_break), .led(led), .digit(digit),
    .display(display)
  );

  always #4 clk = ~clk;

  // select moves one digit left only after SCAN_CYCLES cycles
  assert property (@(posedge clk) disable iff (out_rst)
                   $changed(digit) |-> (digit == {$past(digit[2:0]), $past(digit[3])}) &&
                                       ($past(digit, SCAN_CYCLES) == $past(digit)))
    else begin
      errors++;
      $display("%s: digit select moved wrong, now %b", cur, digit);
    end

  task automatic check_eq(string what, logic [15:0] exp, logic [15:0] act);
    assert (exp === act)
      else begin
        errors++;
        $display("Mismatch %s: %s expected %h actual %h", cur, what, exp, act);
      end
  endtask

  task automatic begin_test(string name);
    cur  = name;
    err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err0) begin
      $display("%s: ok", cur);
    end else begin
      failed_tests++;
      $display("%s: FAILED with %0d errors", cur, errors - err0);
    end
  endtask

  // one full scan, decoded back into nibbles
  task automatic read_display(output nums_t n, output bit full);
    logic [3:0] seen;
    int pos;
    int idx;
    seen = '0;
    n    = '0;
    repeat (4 * SCAN_CYCLES) begin
      @(negedge clk);
      pos = -1;
      idx = -1;
      for (int i = 0; i < 4; i++)
        if (digit == ~(4'b0001 << i)) pos = i;
      for (int j = 0; j < 16; j++)
        if (display == SEG_TABLE[j]) idx = j;
      if (pos >= 0 && idx >= 0) begin
        n[4*pos +: 4] = idx[3:0];
        seen[pos]     = 1'b1;
      end
    end
    full = &seen;
  endtask

  task automatic wait_display(string what, nums_t exp, int max_reads);
    nums_t got;
    bit    full;
    int    tries;
    tries = 0;
    do begin
      read_display(got, full);
      tries++;
    end while ((!full || got !== exp) && tries < max_reads);
    check_eq(what, exp, got);
  endtask

  task automatic wait_led(string what, led_t exp, int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (led !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    check_eq(what, exp, led);
  endtask

  task automatic send_key(scan_code_t code, logic brk);
    @(posedge clk);
    #1;
    key_valid = 1'b1;
    key_code  = code;
    key_break = brk;
    @(posedge clk);
    #1;
    key_valid = 1'b0;
  endtask

  task automatic tap(scan_code_t code);
    send_key(code, 1'b0);
    send_key(code, 1'b1);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
  endtask

  // main row or keypad, picked at random
  function automatic scan_code_t code_of(int d);
    return KEY_CODES[d + 10 * $urandom_range(1, 0)];
  endfunction

  // hit one random lit mole, returns the bit used
  task automatic hit_random(output int b);
    int lit[$];
    int n;
    for (int i = 7; i < 16; i++)
      if (led[i]) lit.push_back(i);
    b = lit[$urandom_range(lit.size() - 1, 0)];
    tap(code_of(16 - b));
    n = 0;
    while (led[b] !== 1'b0 && n < 10) begin
      @(negedge clk);
      n++;
    end
  endtask

  initial begin
    led_t  prev;
    led_t  pattern;
    nums_t got;
    bit    full;
    int    unlit[$];
    int    b;
    int    n;
    int    d1, d2, g1, g2;
    int    score_exp;
    void'($urandom(32'hd7a4_5252));
    clk          = 0;
    out_rst      = 1;
    start        = 0;
    key_valid    = 0;
    key_code     = '0;
    key_break    = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    repeat (5) @(posedge clk);
    #1 out_rst = 0;

    begin_test("reset");
    check_eq("led", 16'h0000, led);
    check_eq("digit", 16'h000E, 16'(digit));  // rightmost digit first
    wait_display("display", BLANK_NUMS, 2);
    end_test();

    begin_test("setup");
    pulse_start();
    wait_led("time mode led", 16'hFF00, 10);
    wait_display("defaults", 16'h3010, 3);
    d1 = $urandom_range(9, 2);  // keeps the game long enough for the hit test
    d2 = $urandom_range(9, 0);
    tap(code_of(d1));
    tap(code_of(d2));
    tap(SPACE_CODE);
    wait_led("goal mode led", 16'h00FF, 10);
    g1 = $urandom_range(9, 5);
    g2 = (g1 + 1 + $urandom_range(8, 0)) % 10;
    tap(code_of(g1));
    send_key(KEY_CODES[g2], 1'b0);
    send_key(KEY_CODES[g2], 1'b0);  // held repeat
    send_key(KEY_CODES[g2], 1'b1);
    wait_display("settings", {d1[3:0], d2[3:0], g1[3:0], g2[3:0]}, 3);
    end_test();

    begin_test("game_hits");
    pulse_start();
    prev      = 16'h00FF;
    score_exp = 0;
    repeat (4) begin
      n = 0;
      @(negedge clk);
      while (led === prev && n < 200) begin
        @(negedge clk);
        n++;
      end
      if (n >= 200) begin
        errors++;
        $display("%s: mole pattern did not change within 200 cycles", cur);
      end
      pattern = led;
      unlit.delete();
      for (int i = 7; i < 16; i++)
        if (!pattern[i]) unlit.push_back(i);
      if (unlit.size() > 0) begin
        b = unlit[$urandom_range(unlit.size() - 1, 0)];
        tap(code_of(16 - b));
        repeat (2) @(negedge clk);
        check_eq("led after miss", pattern, led);
      end
      hit_random(b);
      pattern[b] = 1'b0;
      check_eq("led after hit", pattern, led);
      score_exp++;
      n = 0;
      do begin
        read_display(got, full);
        n++;
      end while (!full && n < 4);
      check_eq("score", 16'(score_exp), 16'(got[7:0]));
      prev = led;
    end
    wait_display("timeout result", LOSE_NUMS, 500);
    wait_display("back to idle", BLANK_NUMS, 30);
    end_test();

    begin_test("win");
    pulse_start();
    wait_led("time mode led", 16'hFF00, 10);
    tap(SPACE_CODE);
    tap(code_of(0));
    tap(code_of(2));
    wait_display("settings", 16'h3002, 3);
    pulse_start();
    wait_led("first moles", {MOLE_SEED, 7'b0}, 10);
    hit_random(b);
    hit_random(b);
    wait_display("win message", WIN_NUMS, 3);
    check_eq("led", 16'h0000, led);
    wait_display("back to idle", BLANK_NUMS, 20);
    end_test();

    begin_test("lose");
    pulse_start();
    wait_led("time mode led", 16'hFF00, 10);
    tap(code_of(0));
    tap(code_of(2));
    wait_display("settings", 16'h0210, 3);
    pulse_start();
    wait_display("two seconds left", 16'h0200, 3);
    wait_display("one second left", 16'h0100, 8);
    wait_display("lose message", LOSE_NUMS, 8);
    pulse_start();  // must not leave the result screen
    wait_display("start in result", LOSE_NUMS, 1);
    wait_display("back to idle", BLANK_NUMS, 20);
    check_eq("led", 16'h0000, led);
    end_test();

    $display("%0d tests, %0d failing, %0d errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== whack_top.sv ====
module whack_top import whack_pkg::*; (
  input  logic       clk,
  input  logic       out_rst,
  input  logic       start,
  input  logic       key_valid,
  input  scan_code_t key_code,
  input  logic       key_break,
  output led_t       led,
  output logic [3:0] digit,
  output seg_t       display
);

  game_ctl_t ctl;
  key_evt_t  evt;
  count_t    time_left;
  count_t    time_limit;
  count_t    goal;
  count_t    score;
  set_mode_t mode;
  nums_t     nums;
  logic      sec_tick;
  logic      final_done;
  logic      goal_hit;
  logic      won;

  game_fsm u_fsm (
    .clk(clk), .out_rst(out_rst), .start(start), .time_left(time_left),
    .goal_hit(goal_hit), .final_done(final_done), .ctl(ctl), .won(won)
  );

  game_timer u_timer (
    .clk(clk), .out_rst(out_rst), .ctl(ctl), .time_limit(time_limit),
    .time_left(time_left), .sec_tick(sec_tick), .final_done(final_done)
  );

  key_mapper u_keys (
    .clk(clk), .out_rst(out_rst), .key_valid(key_valid), .key_code(key_code),
    .key_break(key_break), .evt(evt)
  );

  setting_regs u_settings (
    .clk(clk), .out_rst(out_rst), .ctl(ctl), .evt(evt), .time_left(time_left),
    .score(score), .won(won), .mode(mode), .time_limit(time_limit),
    .goal(goal), .nums(nums)
  );

  mole_board u_moles (
    .clk(clk), .out_rst(out_rst), .ctl(ctl), .sec_tick(sec_tick), .evt(evt),
    .mode(mode), .goal(goal), .led(led), .score(score), .goal_hit(goal_hit)
  );

  seven_seg_mux u_seg (
    .clk(clk), .out_rst(out_rst), .nums(nums), .digit(digit), .display(display)
  );

endmodule
